// ==== src/spim_pkg.sv ====
// LANE_W is fixed at 2 here and must match log2 of the NUM_LANES chosen at spim_top
package spim_pkg;

  //////////////////////////////////////////////////
  // Sizes and reset values
  //////////////////////////////////////////////////

  // Lane index width, sized for four lanes
  localparam int LANE_W = 2;

  // Divider after reset gives a 2 cycle sck half-period
  localparam logic [7:0] DEFAULT_DIV = 8'd1;

  //////////////////////////////////////////////////
  // Command and response types
  //////////////////////////////////////////////////

  // One bit command kind
  typedef enum logic {
    KIND_DATA = 1'b0,
    KIND_CFG  = 1'b1
  } spim_kind_e;

  // Same 8 bits, read per kind
  // clk_div is the half-period in clk cycles minus one
  typedef union packed {
    logic [7:0] data_byte;
    logic [7:0] clk_div;
  } spim_payload_u;

  // What a lane FIFO holds, 9 bits
  typedef struct packed {
    spim_kind_e    kind;
    spim_payload_u payload;
  } spim_entry_t;

  // Incoming command with lane select, 11 bits
  typedef struct packed {
    logic [LANE_W-1:0] lane;
    spim_entry_t       entry;
  } spim_cmd_t;

  // Received byte tagged with its lane, 10 bits
  typedef struct packed {
    logic [LANE_W-1:0] lane;
    logic [7:0]        data;
  } spim_rsp_t;

endpackage

// ==== src/spim_fifo.sv ====
// No overflow or underflow guard, so callers must honour ready and valid; FIFO_DEPTH is 2**ADDR_WIDTH
module spim_fifo #(
  parameter int DATA_WIDTH = 9,
  parameter int ADDR_WIDTH = 2,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rstn,
  // Write side
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] din,
  output logic                  ready,
  // Read side
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] dout,
  output logic                  valid
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [ADDR_WIDTH-1:0] wptr;
  logic [ADDR_WIDTH-1:0] rptr;
  logic [ADDR_WIDTH:0]   status_cnt;
  logic [ADDR_WIDTH:0]   cnt_nxt;
  logic                  full;
  logic                  empty;

  //////////////////////////////////////////////////
  // Pointers
  //////////////////////////////////////////////////

  // Pointers wrap naturally at the depth
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (wr_en) begin
        wptr <= wptr + 1'b1;
      end
      if (rd_en) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Occupancy and flags
  //////////////////////////////////////////////////

  // Next fill level, unchanged on simultaneous read and write
  always_comb begin
    cnt_nxt = status_cnt;
    if (wr_en && !rd_en) begin
      cnt_nxt = status_cnt + 1'b1;
    end else if (rd_en && !wr_en) begin
      cnt_nxt = status_cnt - 1'b1;
    end
  end

  // Flags registered from the next count
  always_ff @(posedge clk) begin
    if (!rstn) begin
      status_cnt <= '0;
      full       <= 1'b0;
      empty      <= 1'b1;
    end else begin
      status_cnt <= cnt_nxt;
      full       <= (cnt_nxt == FIFO_DEPTH);
      empty      <= (cnt_nxt == 0);
    end
  end

  assign ready = !full;
  assign valid = !empty;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wptr] <= din;
    end
  end

  // Head of queue, no read latency
  assign dout = mem[rptr];

endmodule

// ==== src/spim_dispatch.sv ====
// Purely combinational routing; a lane index at or above NUM_LANES is never accepted
module spim_dispatch import spim_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  // Command stream in
  input  spim_cmd_t             cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  // Per-lane FIFO write ports
  input  logic [NUM_LANES-1:0]  lane_ready,
  output logic [NUM_LANES-1:0]  lane_wr,
  output spim_entry_t           lane_entry
);

  logic [NUM_LANES-1:0] lane_sel;
  logic                 accept;

  //////////////////////////////////////////////////
  // Lane decode
  //////////////////////////////////////////////////

  // One-hot select from the lane field
  always_comb begin
    lane_sel = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_sel[i] = (cmd.lane == LANE_W'(i));
    end
  end

  // Ready of the addressed lane only
  // no extra pipeline stage, so ready follows the FIFO flag directly
  assign cmd_ready = |(lane_sel & lane_ready);

  // A transfer on the command stream
  assign accept = cmd_valid && cmd_ready;

  //////////////////////////////////////////////////
  // Write strobes
  //////////////////////////////////////////////////

  // Full check is folded in here
  // lane FIFOs write on the strobe alone
  assign lane_wr = lane_sel & {NUM_LANES{accept}};

  // Entry goes to every lane, strobe picks the one that stores it
  assign lane_entry = cmd.entry;

endmodule

// ==== src/spim_lane.sv ====
// SPI mode 0 only, one byte per cs_n frame; divider changes apply between transfers only
module spim_lane import spim_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int FIFO_AW    = 2
) (
  input  logic        clk,
  input  logic        rstn,
  // Command write port
  input  logic        wr_en,
  input  spim_entry_t wr_entry,
  output logic        wr_ready,
  // SPI pins
  output logic        sck,
  output logic        cs_n,
  output logic        mosi,
  input  logic        miso,
  // Receive holding register
  output logic        rx_valid,
  output logic [7:0]  rx_data,
  input  logic        rx_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOW,
    ST_HIGH,
    ST_GAP
  } lane_state_e;

  lane_state_e state;
  spim_entry_t head;
  logic        head_valid;
  logic        pop;
  logic        half_done;
  logic [7:0]  div_q;
  logic [7:0]  half_cnt;
  logic [7:0]  tx_shift;
  logic [7:0]  rx_shift;
  logic [2:0]  bit_cnt;

  //////////////////////////////////////////////////
  // Command queue
  //////////////////////////////////////////////////

  spim_fifo #(
    .DATA_WIDTH ($bits(spim_entry_t)),
    .ADDR_WIDTH (FIFO_AW),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) cmd_fifo (
    .clk   (clk),
    .rstn  (rstn),
    .wr_en (wr_en),
    .din   (wr_entry),
    .ready (wr_ready),
    .rd_en (pop),
    .dout  (head),
    .valid (head_valid)
  );

  // Config pops freely when idle
  // data waits for an empty holding register
  assign pop = (state == ST_IDLE) && head_valid &&
               ((head.kind == KIND_CFG) || !rx_valid);

  // End of a half-period
  assign half_done = (half_cnt == div_q);

  // MSB first, shift register emptied to zero after the last bit
  assign mosi = tx_shift[7];

  //////////////////////////////////////////////////
  // Shift engine
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= ST_IDLE;
      sck      <= 1'b0;
      cs_n     <= 1'b1;
      div_q    <= DEFAULT_DIV;
      tx_shift <= '0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      // Collector takes the byte
      if (rx_valid && rx_ready) begin
        rx_valid <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          if (pop && (head.kind == KIND_CFG)) begin
            div_q <= head.payload.clk_div;
          end else if (pop) begin
            state    <= ST_LOW;
            cs_n     <= 1'b0;
            tx_shift <= head.payload.data_byte;
            half_cnt <= '0;
            bit_cnt  <= '0;
          end
        end
        // sck low, mosi already set up
        ST_LOW: begin
          if (half_done) begin
            state    <= ST_HIGH;
            sck      <= 1'b1;
            half_cnt <= '0;
          end else begin
            half_cnt <= half_cnt + 8'd1;
          end
        end
        ST_HIGH: begin
          if (half_done) begin
            sck      <= 1'b0;
            half_cnt <= '0;
            tx_shift <= {tx_shift[6:0], 1'b0};
            if (bit_cnt == 3'd7) begin
              // Byte done, release cs_n and hand over the byte
              state    <= ST_GAP;
              cs_n     <= 1'b1;
              rx_valid <= 1'b1;
            end else begin
              state   <= ST_LOW;
              bit_cnt <= bit_cnt + 3'd1;
            end
          end else begin
            half_cnt <= half_cnt + 8'd1;
          end
        end
        // One cycle here plus the pop cycle keeps cs_n high for 2
        ST_GAP: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Sample on the edge where sck rises
    if ((state == ST_LOW) && half_done) begin
      rx_shift <= {rx_shift[6:0], miso};
    end
    // Load holding register as cs_n rises
    if ((state == ST_HIGH) && half_done && (bit_cnt == 3'd7)) begin
      rx_data <= rx_shift;
    end
  end

endmodule

// ==== src/spim_collect.sv ====
// Round-robin over lanes; responses of different lanes may come out in any order
module spim_collect import spim_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  logic                      clk,
  input  logic                      rstn,
  // Lane holding registers
  input  logic [NUM_LANES-1:0]      rx_valid,
  input  logic [NUM_LANES-1:0][7:0] rx_data,
  output logic [NUM_LANES-1:0]      rx_ready,
  // Tagged response stream
  output spim_rsp_t                 rsp,
  output logic                      rsp_valid,
  input  logic                      rsp_ready
);

  logic [LANE_W-1:0] ptr;
  logic [LANE_W-1:0] gnt;
  logic              found;

  //////////////////////////////////////////////////
  // Grant search
  //////////////////////////////////////////////////

  // First valid lane at or after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    gnt   = ptr;
    for (int k = 0; k < NUM_LANES; k++) begin
      idx = (int'(ptr) + k) % NUM_LANES;
      if (!found && rx_valid[idx]) begin
        found = 1'b1;
        gnt   = idx[LANE_W-1:0];
      end
    end
  end

  assign rsp_valid = found;
  assign rsp.lane  = gnt;
  assign rsp.data  = rx_data[gnt];

  // One-hot pop of the winner on a transfer
  always_comb begin
    rx_ready = '0;
    rx_ready[gnt] = found && rsp_ready;
  end

  //////////////////////////////////////////////////
  // Pointer
  //////////////////////////////////////////////////

  // Stall parks the pointer on the winner so rsp holds steady
  // a transfer moves it one past the winner
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ptr <= '0;
    end else if (found && !rsp_ready) begin
      ptr <= gnt;
    end else if (found) begin
      if (gnt == LANE_W'(NUM_LANES - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= gnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/spim_top.sv ====
// NUM_LANES must equal 2**LANE_W from spim_pkg; response order holds within a lane only
module spim_top import spim_pkg::*; #(
  parameter int NUM_LANES  = 4,
  parameter int FIFO_DEPTH = 4,
  parameter int FIFO_AW    = 2
) (
  input  logic                 clk,
  input  logic                 rstn,
  // Command stream
  input  spim_cmd_t            cmd,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  // Response stream
  output spim_rsp_t            rsp,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  // SPI pins, one bit per lane
  output logic [NUM_LANES-1:0] sck,
  output logic [NUM_LANES-1:0] cs_n,
  output logic [NUM_LANES-1:0] mosi,
  input  logic [NUM_LANES-1:0] miso
);

  logic [NUM_LANES-1:0]      lane_wr;
  logic [NUM_LANES-1:0]      lane_ready;
  spim_entry_t               lane_entry;
  logic [NUM_LANES-1:0]      rx_valid;
  logic [NUM_LANES-1:0]      rx_ready;
  logic [NUM_LANES-1:0][7:0] rx_data;

  //////////////////////////////////////////////////
  // Command routing
  //////////////////////////////////////////////////

  spim_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) dispatch_inst (
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .lane_ready (lane_ready),
    .lane_wr    (lane_wr),
    .lane_entry (lane_entry)
  );

  //////////////////////////////////////////////////
  // Lanes
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    spim_lane #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .FIFO_AW    (FIFO_AW)
    ) lane_inst (
      .clk      (clk),
      .rstn     (rstn),
      .wr_en    (lane_wr[i]),
      .wr_entry (lane_entry),
      .wr_ready (lane_ready[i]),
      .sck      (sck[i]),
      .cs_n     (cs_n[i]),
      .mosi     (mosi[i]),
      .miso     (miso[i]),
      .rx_valid (rx_valid[i]),
      .rx_data  (rx_data[i]),
      .rx_ready (rx_ready[i])
    );
  end

  // Response merge
  spim_collect #(
    .NUM_LANES (NUM_LANES)
  ) collect_inst (
    .clk       (clk),
    .rstn      (rstn),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_ready  (rx_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

endmodule

// ==== testbench/spim_assert.sv ====
// Bound to spim_top; NUM_LANES comes from the bound instance
module spim_assert import spim_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input logic                 clk,
  input logic                 rstn,
  input spim_cmd_t            cmd,
  input logic                 cmd_valid,
  input logic                 cmd_ready,
  input spim_rsp_t            rsp,
  input logic                 rsp_valid,
  input logic                 rsp_ready,
  input logic [NUM_LANES-1:0] sck,
  input logic [NUM_LANES-1:0] cs_n,
  input logic [NUM_LANES-1:0] lane_ready
);

  //////////////////////////////////////////////////
  // Per-lane pin and write checks
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_chk
    // Clock idles low outside a frame
    a_sck_idle: assert property (@(posedge clk) disable iff (!rstn) cs_n[i] |-> !sck[i])
      else $error("sck high with cs_n high on lane %0d", i);

    // No command accepted at the top for a lane whose FIFO is full
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
                                    cmd_valid && cmd_ready && (cmd.lane == LANE_W'(i))
                                    |-> lane_ready[i])
      else $error("command accepted for full FIFO on lane %0d", i);
  end

  // Stalled response holds value and lane
  a_rsp_stable: assert property (@(posedge clk) disable iff (!rstn)
                                 rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else $error("response changed while stalled");

endmodule

bind spim_top spim_assert #(.NUM_LANES(NUM_LANES)) assert_inst (
  .clk        (clk),
  .rstn       (rstn),
  .cmd        (cmd),
  .cmd_valid  (cmd_valid),
  .cmd_ready  (cmd_ready),
  .rsp        (rsp),
  .rsp_valid  (rsp_valid),
  .rsp_ready  (rsp_ready),
  .sck        (sck),
  .cs_n       (cs_n),
  .lane_ready (lane_ready)
);

// ==== testbench/tb_spim_top.sv ====
// Slave models assume SPI mode 0 and one byte per frame; expectations assume NUM_LANES = 4
module tb_spim_top import spim_pkg::*; ();

  localparam int NUM_LANES  = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = 2;
  localparam int NUM_RANDOM = 200;
  // 200 commands at about 70 cycles worst case, plus margin
  localparam int MAX_CYCLES = 20000;

  logic                 clk;
  logic                 rstn;
  spim_cmd_t            cmd;
  logic                 cmd_valid;
  logic                 cmd_ready;
  spim_rsp_t            rsp;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [NUM_LANES-1:0] sck;
  logic [NUM_LANES-1:0] cs_n;
  logic [NUM_LANES-1:0] mosi;
  wire  [NUM_LANES-1:0] miso;
  logic                 hold_low;
  logic                 stall_en;
  logic [31:0]          stim_seed;
  logic [31:0]          rdy_seed;
  int                   cycles;

  // Per-lane expectations, filled when a command is accepted
  logic [7:0] rsp_q  [NUM_LANES][$];
  logic [7:0] mosi_q [NUM_LANES][$];
  logic [7:0] div_q  [NUM_LANES][$];
  logic [7:0] lane_div  [NUM_LANES];
  logic [7:0] last_byte [NUM_LANES];
  logic       seen_byte [NUM_LANES];

  spim_top #(
    .NUM_LANES  (NUM_LANES),
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AW    (FIFO_AW)
  ) spim_top_inst (
    .clk       (clk),
    .rstn      (rstn),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .sck       (sck),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Slave echoes the previous byte of its lane, zero before the first
  function automatic logic [7:0] expected_rsp(input logic seen, input logic [7:0] prev);
    return seen ? prev : 8'h00;
  endfunction

  function automatic int pending_count(input bit include_tx);
    int total;
    total = 0;
    for (int i = 0; i < NUM_LANES; i++) begin
      total += rsp_q[i].size();
      if (include_tx) begin
        total += mosi_q[i].size() + div_q[i].size();
      end
    end
    return total;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1, "run stopped on first error");
  endtask

  // Bookkeeping at the handshake edge
  task automatic record_accept(input int lane, input spim_kind_e kind, input logic [7:0] value);
    if (kind == KIND_CFG) begin
      lane_div[lane] = value;
    end else begin
      rsp_q[lane].push_back(expected_rsp(seen_byte[lane], last_byte[lane]));
      mosi_q[lane].push_back(value);
      div_q[lane].push_back(lane_div[lane]);
      seen_byte[lane] = 1'b1;
      last_byte[lane] = value;
    end
  endtask

  // Called on a rising edge, returns on the edge of the transfer
  task automatic send_cmd(input logic [1:0] lane, input spim_kind_e kind,
                          input logic [7:0] value);
    cmd.lane                    <= lane;
    cmd.entry.kind              <= kind;
    cmd.entry.payload.data_byte <= value;
    cmd_valid                   <= 1'b1;
    @(posedge clk);
    while (!cmd_ready) begin
      @(posedge clk);
    end
    record_accept(int'(lane), kind, value);
  endtask

  //////////////////////////////////////////////////
  // Slave models, one per lane
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_slave
    logic [7:0] tx_sh;
    logic [7:0] rx_sh;
    logic [7:0] last_rx;
    logic [7:0] exp_byte;
    logic [7:0] active_div;
    logic       miso_bit;
    int         rises;
    int         hi_cnt;
    int         frames;

    assign miso[i] = miso_bit;

    initial begin
      tx_sh      = '0;
      rx_sh      = '0;
      last_rx    = '0;
      active_div = DEFAULT_DIV;
      miso_bit   = 1'b0;
      rises      = 0;
      hi_cnt     = 0;
      frames     = 0;
    end

    // Frame start, first bit presented before the first rise
    always @(negedge cs_n[i]) begin
      if (rstn) begin
        assert (div_q[i].size() > 0)
          else stop_on_error($sformatf("Lane %0d selected with no data command queued", i));
        active_div = div_q[i].pop_front();
        tx_sh      = last_rx;
        miso_bit   = tx_sh[7];
        rises      = 0;
      end
    end

    always @(negedge sck[i]) begin
      if (!cs_n[i]) begin
        tx_sh    = {tx_sh[6:0], 1'b0};
        miso_bit = tx_sh[7];
      end
    end

    always @(posedge sck[i]) begin
      rx_sh = {rx_sh[6:0], mosi[i]};
      rises++;
    end

    // Frame end, byte on mosi against the queued command
    always @(posedge cs_n[i]) begin
      if (rstn) begin
        frames++;
        last_rx = rx_sh;
        assert (rises == 8)
          else stop_on_error($sformatf("FAIL %0t: lane %0d frame had %0d sck rises",
                                       $time, i, rises));
        assert (mosi_q[i].size() > 0)
          else stop_on_error($sformatf("Lane %0d sent a frame nobody asked for", i));
        exp_byte = mosi_q[i].pop_front();
        assert (rx_sh == exp_byte)
          else stop_on_error($sformatf("FAIL %0t: lane %0d mosi byte %02h, expected %02h",
                                       $time, i, rx_sh, exp_byte));
      end
    end

    // High phase length in clk cycles
    always @(posedge clk) begin
      if (sck[i]) begin
        hi_cnt++;
      end else if (hi_cnt != 0) begin
        assert (hi_cnt == int'(active_div) + 1)
          else stop_on_error($sformatf("FAIL %0t: lane %0d sck high %0d cycles, expected %0d",
                                       $time, i, hi_cnt, int'(active_div) + 1));
        hi_cnt = 0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Random stalls, or a long hold during the back-pressure test
  always @(posedge clk) begin
    if (hold_low) begin
      rsp_ready <= 1'b0;
    end else if (stall_en) begin
      rdy_seed = lcg_next(rdy_seed);
      rsp_ready <= (rdy_seed[31:30] != 2'b00);
    end else begin
      rsp_ready <= 1'b1;
    end
  end

  // Compare each accepted response with the head of its lane queue
  always @(posedge clk) begin
    logic [7:0] exp_rsp;
    if (rstn && rsp_valid && rsp_ready) begin
      assert (rsp_q[rsp.lane].size() > 0)
        else stop_on_error($sformatf("Unexpected extra response on lane %0d", rsp.lane));
      exp_rsp = rsp_q[rsp.lane].pop_front();
      assert (rsp.data == exp_rsp)
        else stop_on_error($sformatf("FAIL %0t: lane %0d response %02h, expected %02h",
                                     $time, rsp.lane, rsp.data, exp_rsp));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      stop_on_error($sformatf("Timeout after %0d cycles, responses still missing", cycles));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    int base_frames;
    rstn      = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    rsp_ready = 1'b1;
    hold_low  = 1'b0;
    stall_en  = 1'b0;
    cycles    = 0;
    stim_seed = 32'hb2f4847a;
    rdy_seed  = 32'hb2f4847a;
    for (int i = 0; i < NUM_LANES; i++) begin
      // 2 cycle sck half-period out of reset
      lane_div[i]  = 8'd1;
      last_byte[i] = '0;
      seen_byte[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    // Pins idle, all FIFOs empty, no response pending
    assert ((cs_n == '1) && (sck == '0) && (mosi == '0) && cmd_ready && !rsp_valid)
      else stop_on_error($sformatf("FAIL %0t: outputs not in their reset state", $time));
    rstn <= 1'b1;
    @(posedge clk);
    stall_en <= 1'b1;

    // Lane 0 with default divider, then dividers 0 and 3
    send_cmd(2'd0, KIND_DATA, 8'ha5);
    send_cmd(2'd0, KIND_DATA, 8'h3c);
    send_cmd(2'd0, KIND_CFG, 8'd0);
    send_cmd(2'd0, KIND_DATA, 8'h81);
    send_cmd(2'd0, KIND_DATA, 8'h7e);
    send_cmd(2'd0, KIND_CFG, 8'd3);
    send_cmd(2'd0, KIND_DATA, 8'hc3);
    send_cmd(2'd0, KIND_DATA, 8'h18);
    send_cmd(2'd0, KIND_CFG, 8'd1);

    // Back-pressure on lane 1, holding register plus a full FIFO
    hold_low    <= 1'b1;
    base_frames = g_slave[1].frames;
    for (int k = 0; k < FIFO_DEPTH + 1; k++) begin
      send_cmd(2'd1, KIND_DATA, 8'h40 + 8'(k));
    end
    cmd_valid <= 1'b0;
    while (g_slave[1].frames == base_frames) begin
      @(posedge clk);
    end
    // Long enough for a wrongly started second pop to show on the flag
    repeat (4) @(posedge clk);
    assert (!cmd_ready)
      else stop_on_error($sformatf("FAIL %0t: cmd_ready high for a full lane 1", $time));
    cmd.lane <= 2'd2;
    @(posedge clk);
    @(posedge clk);
    assert (cmd_ready)
      else stop_on_error($sformatf("FAIL %0t: cmd_ready low for idle lane 2", $time));
    repeat (100) @(posedge clk);
    hold_low <= 1'b0;

    // Random traffic on all lanes, about one config in eight
    for (int n = 0; n < NUM_RANDOM; n++) begin
      stim_seed = lcg_next(stim_seed);
      if (stim_seed[30:28] == 3'd0) begin
        send_cmd(stim_seed[17:16], KIND_CFG, {6'd0, stim_seed[21:20]});
      end else begin
        send_cmd(stim_seed[17:16], KIND_DATA, stim_seed[27:20]);
      end
    end
    cmd_valid <= 1'b0;

    // Drain, then every frame and response must be accounted for
    while (pending_count(1'b0) != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    if (pending_count(1'b1) == 0) begin
      $display("Verification passed");
    end else begin
      stop_on_error("Frames still outstanding after all responses arrived");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
src/spim_pkg.sv
src/spim_fifo.sv
src/spim_dispatch.sv
src/spim_lane.sv
src/spim_collect.sv
src/spim_top.sv
testbench/spim_assert.sv
testbench/tb_spim_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_spim_top
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
